// File: source/gba_loader_pkg.sv
`default_nettype none

package gba_loader_pkg;

	// ========================================================================
	// Download bus and beat types
	// ========================================================================

	localparam int ROM_ADDR_W  = 27;
	localparam int BIOS_ADDR_W = 12;

	localparam logic [7:0] INDEX_BIOS  = 8'd0;
	localparam logic [7:0] INDEX_CHEAT = 8'd255;

	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_BIOS,
		LOAD_CART,
		LOAD_CHEAT
	} load_kind_e;

	typedef struct packed {
		logic                  download;
		logic [7:0]            index;
		logic [ROM_ADDR_W-1:0] addr;     // Byte address, always even
		logic [15:0]           dout;
		logic                  wr;
	} ioctl_bus_t;

	typedef struct packed {
		load_kind_e            kind;
		logic [ROM_ADDR_W-1:0] addr;
		logic [15:0]           dout;
		logic                  wr;
	} load_beat_t;

	typedef struct packed {
		logic [BIOS_ADDR_W-1:0] addr;    // Word address
		logic [31:0]            data;
		logic                   wr;
	} bios_write_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic sram;    // Hide SRAM from games that probe it as emulator detection
		logic remap;   // Mirror a small ROM across the full pak space
		logic gpio;
		logic tilt;
		logic solar;
		logic sprite;  // Needs the full sprite pixel budget per line
	} cart_quirks_t;

	// ========================================================================
	// Cartridge header and signatures
	// ========================================================================

	localparam logic [ROM_ADDR_W-1:0] HDR_ID_ADDR     = 27'h0AC;
	localparam logic [ROM_ADDR_W-1:0] HDR_DECIDE_ADDR = 27'h0B0;

	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";

	localparam cart_quirks_t Q_NONE   = 6'b00_0000;
	localparam cart_quirks_t Q_SRAM   = 6'b10_0000;
	localparam cart_quirks_t Q_REMAP  = 6'b01_0000;
	localparam cart_quirks_t Q_GPIO   = 6'b00_1000;
	localparam cart_quirks_t Q_TILT   = 6'b00_0100;
	localparam cart_quirks_t Q_SOLAR  = 6'b00_0010;
	localparam cart_quirks_t Q_SPRITE = 6'b00_0001;

	// Entry compares the top id_len characters of the ID, left aligned
	typedef struct packed {
		logic [31:0]  id;
		logic [2:0]   id_len;
		cart_quirks_t set;
		cart_quirks_t clr;  // Applied after all set masks are merged
	} quirk_entry_t;

	localparam int QUIRK_COUNT = 31;

	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{{"AR8", 8'h00}, 3'd3, Q_SRAM, Q_NONE},   // Rocky
		'{{"ARO", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"ALG", 8'h00}, 3'd3, Q_SRAM, Q_NONE},   // Dragon Ball Z series
		'{{"ALF", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"BLF", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"BDB", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"BG3", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"BDV", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"A2Y", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"AI2", 8'h00}, 3'd3, Q_SRAM, Q_NONE},
		'{{"BPE", 8'h00}, 3'd3, Q_GPIO, Q_NONE},   // RTC carts
		'{{"AXV", 8'h00}, 3'd3, Q_GPIO, Q_NONE},
		'{{"AXP", 8'h00}, 3'd3, Q_GPIO, Q_NONE},
		'{{"RZW", 8'h00}, 3'd3, Q_GPIO, Q_NONE},
		'{{"BKA", 8'h00}, 3'd3, Q_GPIO, Q_NONE},
		'{{"BR4", 8'h00}, 3'd3, Q_GPIO, Q_NONE},
		'{{"BHG", 8'h00}, 3'd3, Q_SPRITE, Q_NONE},
		'{{"BGX", 8'h00}, 3'd3, Q_SPRITE, Q_NONE},
		'{{"K", 24'h0}, 3'd1, Q_TILT, Q_NONE},                // Tilt sensor class
		'{{"U", 24'h0}, 3'd1, cart_quirks_t'(Q_GPIO | Q_SOLAR), Q_NONE},
		'{{"F", 24'h0}, 3'd1, cart_quirks_t'(Q_SRAM | Q_REMAP), Q_NONE},
		'{"FSDJ", 3'd4, Q_SPRITE, Q_NONE},
		'{"FADJ", 3'd4, Q_SPRITE, Q_NONE},
		'{"FTUJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FTKJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FFMJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FLBJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FPTJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FMRJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FNMJ", 3'd4, Q_SPRITE, Q_REMAP},
		'{"FM2J", 3'd4, Q_SPRITE, Q_NONE}
	};

endpackage

`default_nettype wire

// File: source/loader_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module loader_ctrl import gba_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  ioctl_bus_t            ioctl,
	output load_beat_t            beat,
	output logic                  cart_start,
	output logic                  cheat_clear,
	output logic                  cart_loaded,
	output logic [ROM_ADDR_W-1:0] cart_size
);

	load_kind_e            bus_kind;
	logic                  download_q;
	logic                  dl_rise;
	logic                  dl_fall;
	logic                  cheat_rise_q;   // First stage of the clear pulse
	logic                  cart_fall_q;    // Cartridge download just ended
	logic [ROM_ADDR_W-1:0] last_addr;

	// Index decode, only meaningful while a download is open
	always_comb begin
		if (!ioctl.download)
			bus_kind = LOAD_NONE;
		else if (ioctl.index == INDEX_BIOS)
			bus_kind = LOAD_BIOS;
		else if (ioctl.index == INDEX_CHEAT)
			bus_kind = LOAD_CHEAT;
		else
			bus_kind = LOAD_CART;
	end

	assign dl_rise = ioctl.download & ~download_q;
	assign dl_fall = ~ioctl.download & download_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			beat.kind <= LOAD_NONE;
			beat.wr   <= 1'b0;
		end else begin
			beat.kind <= bus_kind;
			beat.wr   <= ioctl.wr & ioctl.download;
		end
		beat.addr <= ioctl.addr;
		beat.dout <= ioctl.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q   <= 1'b0;
			cart_start   <= 1'b0;
			cheat_rise_q <= 1'b0;
			cheat_clear  <= 1'b0;
			cart_fall_q  <= 1'b0;
			cart_loaded  <= 1'b0;
			cart_size    <= '0;
		end else begin
			download_q   <= ioctl.download;
			cart_start   <= dl_rise & (bus_kind == LOAD_CART);
			cheat_rise_q <= dl_rise & (bus_kind == LOAD_CHEAT);
			cheat_clear  <= cheat_rise_q;
			cart_fall_q  <= dl_fall & (beat.kind == LOAD_CART);  // beat still holds the old kind
			if (cart_fall_q) begin
				cart_loaded <= 1'b1;
				cart_size   <= last_addr;
			end
		end
	end

	// Highest address seen so far in the cartridge image
	always_ff @(posedge clk_sys) begin
		if (beat.wr && beat.kind == LOAD_CART)
			last_addr <= beat.addr;
	end

	// One download feeds one datapath only
	a_kind_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(beat.kind != LOAD_NONE && $past(beat.kind) != LOAD_NONE)
			|-> beat.kind == $past(beat.kind))
		else $error("beat kind changed inside a download");

endmodule

`default_nettype wire

// File: source/bios_word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module bios_word_packer import gba_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset,
	input  load_beat_t  beat,
	input  wire         homebrew_bios,
	output bios_write_t bios_write
);

	logic        bios_wr;
	logic [15:0] low_half;   // Even halfword waiting for its partner

	// Homebrew BIOS lives in the core, so the download is dropped
	assign bios_wr = beat.wr & (beat.kind == LOAD_BIOS) & ~homebrew_bios;

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_write.wr <= 1'b0;
		else
			bios_write.wr <= bios_wr & beat.addr[1];

		if (bios_wr) begin
			if (!beat.addr[1]) begin
				low_half <= beat.dout;
			end else begin
				bios_write.data <= {beat.dout, low_half};
				bios_write.addr <= beat.addr[BIOS_ADDR_W+1:2];  // Byte to word address
			end
		end
	end

	// Odd halfwords never arrive back to back on the download bus
	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		bios_write.wr |=> !bios_write.wr)
		else $error("BIOS write strobe high on consecutive cycles");

endmodule

`default_nettype wire

// File: source/cheat_code_packer.sv
`timescale 1ns/100ps
`default_nettype none

module cheat_code_packer import gba_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset,
	input  load_beat_t  beat,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

	// ========================================================================
	// Record layout, 16 bytes per code
	//   0..3 flags, 4..7 address, 8..11 compare, 12..15 replace
	// ========================================================================

	logic       code_wr;
	logic [2:0] half_sel;   // Halfword slot inside the record

	assign code_wr  = beat.wr & (beat.kind == LOAD_CHEAT);
	assign half_sel = beat.addr[3:1];

	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr & (half_sel == 3'd7);  // Last halfword closes the code

		if (code_wr) begin
			case (half_sel)
				3'd0: cheat_code.flags[15:0]    <= beat.dout;
				3'd1: cheat_code.flags[31:16]   <= beat.dout;
				3'd2: cheat_code.address[15:0]  <= beat.dout;
				3'd3: cheat_code.address[31:16] <= beat.dout;
				3'd4: cheat_code.compare[15:0]  <= beat.dout;
				3'd5: cheat_code.compare[31:16] <= beat.dout;
				3'd6: cheat_code.replace[15:0]  <= beat.dout;
				default: cheat_code.replace[31:16] <= beat.dout;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/cart_header_scan.sv
`timescale 1ns/100ps
`default_nettype none

module cart_header_scan import gba_loader_pkg::*; (
	input  wire          clk_sys,
	input  wire          reset,
	input  load_beat_t   beat,
	input  wire          cart_start,
	output cart_quirks_t quirks
);

	logic         cart_wr;
	logic [31:0]  cart_id;     // Four ASCII characters, first one on top
	cart_quirks_t set_any;
	cart_quirks_t clr_any;
	cart_quirks_t set_q;
	cart_quirks_t clr_q;
	logic         decide_q;

	// Compare only the leading characters that the entry cares about
	function automatic logic id_match(input logic [31:0] id, input quirk_entry_t entry);
		logic [31:0] mask;
		mask = 32'hFFFF_FFFF << (8 * (4 - entry.id_len));
		return (id & mask) == (entry.id & mask);
	endfunction

	assign cart_wr = beat.wr & (beat.kind == LOAD_CART);

	// ========================================================================
	// Game ID capture
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (beat.addr == HDR_ID_ADDR)
				cart_id[31:16] <= {beat.dout[7:0], beat.dout[15:8]};  // Low byte is the earlier char
			if (beat.addr == HDR_ID_ADDR + 27'd2)
				cart_id[15:0] <= {beat.dout[7:0], beat.dout[15:8]};
		end
	end

	// ========================================================================
	// Table lookup, two stages
	// ========================================================================

	// Merge every matching entry; prefix and class entries can both hit
	always_comb begin
		set_any = Q_NONE;
		clr_any = Q_NONE;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (id_match(cart_id, QUIRK_TABLE[i])) begin
				set_any = set_any | QUIRK_TABLE[i].set;
				clr_any = clr_any | QUIRK_TABLE[i].clr;
			end
		end
	end

	// First stage holds the merged masks
	always_ff @(posedge clk_sys) begin
		if (reset)
			decide_q <= 1'b0;
		else
			decide_q <= cart_wr & (beat.addr == HDR_DECIDE_ADDR);

		if (cart_wr && beat.addr == HDR_DECIDE_ADDR) begin
			set_q <= set_any;
			clr_q <= clr_any;
		end
	end

	// Overrides win over class masks
	always_ff @(posedge clk_sys) begin
		if (reset)
			quirks <= Q_NONE;
		else if (cart_start)
			quirks <= Q_NONE;  // New image, forget the last game
		else if (decide_q)
			quirks <= set_q & ~clr_q;
	end

endmodule

`default_nettype wire

// File: source/flash_id_scan.sv
`timescale 1ns/100ps
`default_nettype none

module flash_id_scan import gba_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  load_beat_t beat,
	input  wire        cart_start,
	output logic       flash_1m
);

	logic        cart_wr;
	logic [63:0] window;      // Last eight bytes of the image, newest at the bottom
	logic [63:0] win_base;
	logic [7:0]  byte_lo;
	logic [7:0]  byte_hi;
	logic        sig_hit;

	assign cart_wr  = beat.wr & (beat.kind == LOAD_CART);
	assign win_base = cart_start ? 64'd0 : window;  // First beat may share the start cycle
	assign byte_lo  = beat.dout[7:0];
	assign byte_hi  = beat.dout[15:8];

	// Signature may end on either byte of the halfword
	assign sig_hit = cart_wr & (({win_base, byte_lo} == FLASH_SIG) |
		({win_base[55:0], byte_lo, byte_hi} == FLASH_SIG));

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			window <= {win_base[47:0], byte_lo, byte_hi};
		else if (cart_start)
			window <= '0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			flash_1m <= 1'b0;
		else if (cart_start)
			flash_1m <= 1'b0;
		else if (sig_hit)
			flash_1m <= 1'b1;  // Sticky until the next cartridge
	end

endmodule

`default_nettype wire

// File: source/gba_loader.sv
`timescale 1ns/100ps
`default_nettype none

module gba_loader import gba_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  ioctl_bus_t            ioctl,
	input  wire                   homebrew_bios,
	output bios_write_t           bios_write,
	output cheat_code_t           cheat_code,
	output logic                  cheat_valid,
	output logic                  cheat_clear,
	output cart_quirks_t          quirks,
	output logic                  flash_1m,
	output logic                  cart_loaded,
	output logic [ROM_ADDR_W-1:0] cart_size
);

	load_beat_t beat;       // Registered bus, shared by every datapath
	logic       cart_start;

	loader_ctrl loader_ctrl_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.beat        (beat),
		.cart_start  (cart_start),
		.cheat_clear (cheat_clear),
		.cart_loaded (cart_loaded),
		.cart_size   (cart_size)
	);

	bios_word_packer bios_word_packer_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.beat          (beat),
		.homebrew_bios (homebrew_bios),
		.bios_write    (bios_write)
	);

	cheat_code_packer cheat_code_packer_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.beat        (beat),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	cart_header_scan cart_header_scan_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat       (beat),
		.cart_start (cart_start),
		.quirks     (quirks)
	);

	flash_id_scan flash_id_scan_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat       (beat),
		.cart_start (cart_start),
		.flash_1m   (flash_1m)
	);

endmodule

`default_nettype wire

// File: tb/tb_gba_loader_model.svh
`ifndef TB_GBA_LOADER_MODEL_SVH
`define TB_GBA_LOADER_MODEL_SVH

// ========================================================================
// Random source
// ========================================================================

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic [31:0] next;
	next = {1'b0, state[31:1]};
	if (state[0])
		next = next ^ 32'h8020_0003;
	return next;
endfunction

function logic [15:0] random_half();
	logic [15:0] value;
	value = '0;
	for (int i = 0; i < 16; i++) begin
		value      = {value[14:0], lfsr_state[0]};  // One step per bit taken
		lfsr_state = lfsr_next(lfsr_state);
	end
	return value;
endfunction

// ========================================================================
// Expected results
// ========================================================================

localparam logic [71:0] SIG_TEXT = "FLASH1M_V";

// Word address and data of the write that the high halfword completes
function automatic logic [43:0] pack_bios_word(input logic [26:0] hi_addr,
	input logic [15:0] lo, input logic [15:0] hi);
	logic [26:0] word_addr;
	word_addr = hi_addr >> 2;
	return {word_addr[11:0], hi, lo};
endfunction

// Halves packed with halfword 0 at the bottom
function automatic cheat_code_t assemble_cheat(input logic [127:0] halves);
	cheat_code_t code;
	code.flags   = halves[31:0];
	code.address = halves[63:32];
	code.compare = halves[95:64];
	code.replace = halves[127:96];
	return code;
endfunction

function automatic cart_quirks_t lookup_quirks(input logic [31:0] id);
	cart_quirks_t q;
	q = '0;
	case (id[31:8])
		"AR8", "ARO", "ALG", "ALF", "BLF", "BDB", "BG3", "BDV", "A2Y", "AI2": q.sram = 1'b1;
		"BPE", "AXV", "AXP", "RZW", "BKA", "BR4": q.gpio = 1'b1;
		"BHG", "BGX": q.sprite = 1'b1;
		default: ;
	endcase
	case (id[31:24])
		"K": q.tilt = 1'b1;
		"U": begin
			q.gpio  = 1'b1;
			q.solar = 1'b1;
		end
		"F": begin
			q.sram  = 1'b1;
			q.remap = 1'b1;
		end
		default: ;
	endcase
	// Four character overrides come last
	case (id)
		"FSDJ", "FADJ", "FM2J": q.sprite = 1'b1;
		"FTUJ", "FTKJ", "FFMJ", "FLBJ", "FPTJ", "FMRJ", "FNMJ": begin
			q.sprite = 1'b1;
			q.remap  = 1'b0;
		end
		default: ;
	endcase
	return q;
endfunction

// Plain search over the first nbytes of the image
function automatic logic find_flash_sig(input int nbytes);
	logic hit;
	logic match;
	hit = 1'b0;
	for (int i = 0; i + 9 <= nbytes; i++) begin
		match = 1'b1;
		for (int k = 0; k < 9; k++)
			if (image[i + k] != SIG_TEXT[71 - 8*k -: 8])
				match = 1'b0;
		hit = hit | match;
	end
	return hit;
endfunction

`endif

// File: tb/tb_gba_loader.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gba_loader import gba_loader_pkg::*; ();

	localparam int BIOS_HALVES  = 32;
	localparam int CHEAT_HALVES = 16;
	localparam int NUM_CARTS    = 6;
	localparam int CART_MAX     = 128;  // Halfwords in the largest image
	localparam int CYCLE_LIMIT  = 2 * BIOS_HALVES + CHEAT_HALVES + NUM_CARTS * CART_MAX
		+ 10 * (NUM_CARTS + 3) + 200;
	localparam logic [26:0] BIOS_BASE = 27'h7FC0;  // Top bits fall off the word address

	logic         clk_sys;
	logic         reset;
	ioctl_bus_t   ioctl;
	logic         homebrew_bios;
	bios_write_t  bios_write;
	cheat_code_t  cheat_code;
	logic         cheat_valid;
	logic         cheat_clear;
	cart_quirks_t quirks;
	logic         flash_1m;
	logic         cart_loaded;
	logic [26:0]  cart_size;

	logic [31:0]  lfsr_state;
	logic [7:0]   image [0:2*CART_MAX-1];
	logic [43:0]  bios_expected [$];
	cheat_code_t  cheat_expected [$];
	logic         check_cart;   // One cycle window for the completion checks
	cart_quirks_t exp_quirks;
	logic         exp_flash;
	logic [26:0]  exp_size;
	logic [43:0]  exp_word;
	cheat_code_t  exp_code;
	int           clear_count = 0;
	int           checks = 0;
	int           errors = 0;
	int           cycle_count = 0;

	`include "tb_gba_loader_model.svh"

	gba_loader gba_loader_inst (.*);

	always #10 clk_sys = ~clk_sys;

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		errors++;
		$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
	endtask

	// ========================================================================
	// Download bus driving, always on the falling edge
	// ========================================================================

	task automatic write_half(input logic [26:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic open_download(input logic [7:0] index);
		ioctl.index    = index;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic close_download();
		ioctl.wr       = 1'b0;
		ioctl.download = 1'b0;
	endtask

	task automatic bios_download(input logic expect_writes);
		logic [15:0] data;
		logic [15:0] low;
		logic [26:0] addr;
		open_download(8'd0);
		for (int i = 0; i < BIOS_HALVES; i++) begin
			data = random_half();
			addr = BIOS_BASE + 27'(2 * i);
			if (!addr[1])
				low = data;
			else if (expect_writes)
				bios_expected.push_back(pack_bios_word(addr, low, data));
			write_half(addr, data);
		end
		close_download();
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic cheat_download();
		logic [127:0] halves;
		open_download(8'd255);
		for (int r = 0; r < CHEAT_HALVES / 8; r++) begin
			for (int h = 0; h < 8; h++)
				halves[16*h +: 16] = random_half();
			cheat_expected.push_back(assemble_cheat(halves));
			for (int h = 0; h < 8; h++)
				write_half(27'(16 * r + 2 * h), halves[16*h +: 16]);
		end
		close_download();
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic cart_download(input logic [7:0] index, input logic [31:0] id,
		input int sig_at, input int halves);
		for (int a = 0; a < halves; a++)
			{image[2*a+1], image[2*a]} = random_half();
		for (int k = 0; k < 4; k++)
			image['hAC + k] = id[31 - 8*k -: 8];  // First character at the lowest address
		if (sig_at >= 0)
			for (int k = 0; k < 9; k++)
				image[sig_at + k] = SIG_TEXT[71 - 8*k -: 8];
		open_download(index);
		for (int a = 0; a < halves; a++)
			write_half(27'(2 * a), {image[2*a+1], image[2*a]});
		close_download();
		repeat (2) @(negedge clk_sys);  // Completion lands 2 cycles after download falls
		exp_quirks = lookup_quirks(id);
		exp_flash  = find_flash_sig(2 * halves);
		exp_size   = 27'(2 * (halves - 1));
		check_cart = 1'b1;
		@(negedge clk_sys);
		check_cart = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// ========================================================================
	// Comparison against the model, on values stable since the last edge
	// ========================================================================

	always @(posedge clk_sys) begin
		if (!reset) begin
			if (bios_write.wr) begin
				if (bios_expected.size() == 0) begin
					errors++;
					$display("BIOS write to word %0h when none was expected", bios_write.addr);
				end else begin
					exp_word = bios_expected.pop_front();
					checks++;
					if ({bios_write.addr, bios_write.data} !== exp_word)
						report_mismatch("bios_write", 128'(exp_word),
							128'({bios_write.addr, bios_write.data}));
				end
			end
			if (cheat_valid) begin
				if (cheat_expected.size() == 0) begin
					errors++;
					$display("Cheat code strobe with no code expected");
				end else begin
					exp_code = cheat_expected.pop_front();
					checks++;
					if (cheat_code !== exp_code)
						report_mismatch("cheat_code", exp_code, cheat_code);
				end
			end
			if (cheat_clear)
				clear_count++;
			if (check_cart) begin
				checks += 4;
				if (quirks !== exp_quirks)
					report_mismatch("quirks", 128'(exp_quirks), 128'(quirks));
				if (flash_1m !== exp_flash)
					report_mismatch("flash_1m", 128'(exp_flash), 128'(flash_1m));
				if (cart_loaded !== 1'b1)
					report_mismatch("cart_loaded", 128'(1'b1), 128'(cart_loaded));
				if (cart_size !== exp_size)
					report_mismatch("cart_size", 128'(exp_size), 128'(cart_size));
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		clk_sys       = 1'b0;
		reset         = 1'b1;
		ioctl         = '0;
		homebrew_bios = 1'b0;
		check_cart    = 1'b0;
		lfsr_state    = 32'h294;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		checks++;
		if (cart_loaded !== 1'b0 || flash_1m !== 1'b0 || quirks !== '0 || bios_write.wr !== 1'b0)
		begin
			errors++;
			$display("Outputs were not cleared by reset");
		end

		bios_download(1'b1);
		homebrew_bios = 1'b1;  // Same stream again, all writes dropped
		bios_download(1'b0);
		homebrew_bios = 1'b0;

		cheat_download();

		cart_download(8'd1, "AR8E", 'h40, 128);  // Signature ends on a low byte
		cart_download(8'd2, "BPEE", 'h61, 120);  // Signature ends on a high byte
		cart_download(8'd3, "KYGE", -1, 96);
		cart_download(8'd4, "U3IJ", -1, 100);
		cart_download(8'd5, "FMRJ", -1, 112);
		cart_download(8'd6, "ZZZE", -1, 90);     // Unknown game
		repeat (4) @(negedge clk_sys);

		if (bios_expected.size() != 0) begin
			errors++;
			$display("%0d BIOS writes never appeared", bios_expected.size());
		end
		if (cheat_expected.size() != 0) begin
			errors++;
			$display("%0d cheat codes never appeared", cheat_expected.size());
		end
		checks++;
		if (clear_count != 1)
			report_mismatch("cheat_clear count", 128'(1), 128'(clear_count));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: gba_loader.f
+incdir+tb
source/gba_loader_pkg.sv
source/loader_ctrl.sv
source/bios_word_packer.sv
source/cheat_code_packer.sv
source/cart_header_scan.sv
source/flash_id_scan.sv
source/gba_loader.sv
tb/tb_gba_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the loader testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_gba_loader -f gba_loader.f \
	--Mdir "$BUILD_DIR" -o tb_gba_loader; then
	echo "Verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/tb_gba_loader" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qxF '** PASS **' "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG_FILE"
exit 1
